// File: source/controller_params.svh
`ifndef CONTROLLER_PARAMS_SVH
`define CONTROLLER_PARAMS_SVH

`define CTRL_WORD_WIDTH     16 // instruction register width
`define CTRL_BYTE_WIDTH     8  // memory returns one byte per read
`define CTRL_STEP_COUNT     8  // T0 to T7
`define CTRL_OPCODE_WIDTH   6
`define CTRL_REG_CODE_WIDTH 3  // msb set selects the register file

`endif

// File: source/controlPkg.sv
`include "controller_params.svh"

package controlPkg;

    typedef enum logic [`CTRL_OPCODE_WIDTH-1:0] {
        opBra  = 6'h00,
        opBne  = 6'h01,
        opBeq  = 6'h02,
        opInc  = 6'h05,
        opDec  = 6'h06,
        opLsl  = 6'h07,
        opLsr  = 6'h08,
        opAsr  = 6'h09,
        opCsl  = 6'h0A,
        opCsr  = 6'h0B,
        opAnd  = 6'h0C,
        opOr   = 6'h0D,
        opNot  = 6'h0E,
        opXor  = 6'h0F,
        opNand = 6'h10,
        opMovh = 6'h11,
        opMovl = 6'h14,
        opAdd  = 6'h15,
        opAdc  = 6'h16,
        opSub  = 6'h17,
        opLdi  = 6'h20
    } opcodeT;

    typedef enum logic [2:0] {
        rfDec      = 3'b000,
        rfInc      = 3'b001,
        rfLoad     = 3'b010,
        rfLoadLow  = 3'b101,
        rfLoadHigh = 3'b110,
        rfHold     = 3'b111
    } rfFunT;

    typedef enum logic [2:0] {
        arfDec      = 3'b000,
        arfInc      = 3'b001,
        arfLoad     = 3'b010,
        arfLoadLow  = 3'b101,
        arfLoadHigh = 3'b110,
        arfHold     = 3'b111
    } arfFunT;

    typedef enum logic [4:0] {
        aluPassA    = 5'b10000,
        aluNotA     = 5'b10010,
        aluAdd      = 5'b10100,
        aluAddCarry = 5'b10101,
        aluSub      = 5'b10110,
        aluAnd      = 5'b10111,
        aluOr       = 5'b11000,
        aluXor      = 5'b11001,
        aluNand     = 5'b11010,
        aluLsl      = 5'b11011,
        aluLsr      = 5'b11100,
        aluAsr      = 5'b11101,
        aluCsl      = 5'b11110,
        aluCsr      = 5'b11111
    } aluFunT;

    typedef enum logic [1:0] {
        muxAAlu     = 2'b00,
        muxAArfOutC = 2'b01,
        muxAMemory  = 2'b10,
        muxAIrLow   = 2'b11
    } muxASelT;

    typedef enum logic [1:0] {
        muxBAlu     = 2'b00,
        muxBArfOutC = 2'b01,
        muxBMemory  = 2'b10
    } muxBSelT;

    typedef enum logic [2:0] {
        wtNone,
        wtDestination,
        wtRselReg,
        wtScratch1,
        wtScratch2,
        wtProgramCounter
    } writeTargetT;

    typedef enum logic [1:0] {
        wsAlu,
        wsIrLow,
        wsArfOut
    } writeSourceT;

    typedef enum logic [2:0] {
        classBranch,
        classIncDec,
        classUnary,
        classBinary,
        classImmediate,
        classNoOp
    } opClassT;

endpackage

// File: source/sequenceCounter.sv
`timescale 1ns/1ps
`include "controller_params.svh"

module sequenceCounter (
    input  logic                        Clock,
    input  logic                        rst,
    input  logic                        instrDone,
    output logic [`CTRL_STEP_COUNT-1:0] step,
    output logic                        running
);
    localparam int CountWidth = $clog2(`CTRL_STEP_COUNT);

    logic [CountWidth-1:0] count;

    always_ff @(posedge Clock) begin
        if (rst) begin
            count   <= '0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (!running || instrDone) begin
                count <= '0; // next cycle fetches
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    always_comb begin
        step        = '0;
        step[count] = 1'b1;
    end

    // longest instruction is five cycles, so T5 and up stay unused
    stepInRange: assert property (@(posedge Clock) disable iff (rst)
        running |-> step[`CTRL_STEP_COUNT-1:5] == '0);

    // the sequencer may only close an instruction after both bytes are in
    noDoneInFetch: assert property (@(posedge Clock) disable iff (rst)
        running && (step[0] || step[1]) |-> !instrDone);

endmodule

// File: source/instructionDecoder.sv
`timescale 1ns/1ps
`include "controller_params.svh"

module instructionDecoder
    import controlPkg::*;
(
    input  logic                           Clock,
    input  logic                           rst,
    input  logic [`CTRL_STEP_COUNT-1:0]    step,
    input  logic                           running,
    input  logic [`CTRL_BYTE_WIDTH-1:0]    memData,
    output logic [`CTRL_BYTE_WIDTH-1:0]    irLow,
    output opClassT                        opClass,
    output aluFunT                         aluOp,
    output logic [1:0]                     rsel,
    output logic [`CTRL_REG_CODE_WIDTH-1:0] destCode,
    output logic [`CTRL_REG_CODE_WIDTH-1:0] src1Code,
    output logic [`CTRL_REG_CODE_WIDTH-1:0] src2Code,
    output logic                           src1InRf,
    output logic                           src2InRf,
    output logic                           isIncrement,
    output logic [1:0]                     branchKind,
    output logic [1:0]                     immediateKind
);
    logic [`CTRL_WORD_WIDTH-1:0] ir;
    opcodeT                      opcode;

    always_ff @(posedge Clock) begin
        if (rst) begin
            ir <= '0;
        end else if (running) begin
            if (step[0]) begin
                ir[`CTRL_BYTE_WIDTH-1:0] <= memData; // low byte first
            end
            if (step[1]) begin
                ir[`CTRL_WORD_WIDTH-1:`CTRL_BYTE_WIDTH] <= memData;
            end
        end
    end

    assign opcode      = opcodeT'(ir[`CTRL_WORD_WIDTH-1 -: `CTRL_OPCODE_WIDTH]);
    assign rsel        = ir[9:8];
    assign irLow       = ir[`CTRL_BYTE_WIDTH-1:0];
    assign destCode    = {rsel[0], ir[7:6]};
    assign src1Code    = ir[5:3];
    assign src2Code    = ir[2:0];
    assign src1InRf    = src1Code[`CTRL_REG_CODE_WIDTH-1];
    assign src2InRf    = src2Code[`CTRL_REG_CODE_WIDTH-1];
    assign isIncrement = (opcode == opInc);
    assign branchKind  = opcode[1:0]; // BRA 00, BNE 01, BEQ 10

    always_comb begin
        case (opcode)
            opBra, opBne, opBeq:                             opClass = classBranch;
            opInc, opDec:                                    opClass = classIncDec;
            opLsl, opLsr, opAsr, opCsl, opCsr, opNot:        opClass = classUnary;
            opAnd, opOr, opXor, opNand, opAdd, opAdc, opSub: opClass = classBinary;
            opMovh, opMovl, opLdi:                           opClass = classImmediate;
            default:                                         opClass = classNoOp;
        endcase

        case (opcode)
            opBra, opBne, opBeq, opAdd: aluOp = aluAdd; // branches add offset to PC
            opAdc:   aluOp = aluAddCarry;
            opSub:   aluOp = aluSub;
            opAnd:   aluOp = aluAnd;
            opOr:    aluOp = aluOr;
            opXor:   aluOp = aluXor;
            opNand:  aluOp = aluNand;
            opNot:   aluOp = aluNotA;
            opLsl:   aluOp = aluLsl;
            opLsr:   aluOp = aluLsr;
            opAsr:   aluOp = aluAsr;
            opCsl:   aluOp = aluCsl;
            opCsr:   aluOp = aluCsr;
            default: aluOp = aluPassA;
        endcase

        // bit 1 marks a half load, bit 0 picks the high half
        case (opcode)
            opMovh:  immediateKind = 2'b11;
            opMovl:  immediateKind = 2'b10;
            default: immediateKind = 2'b00;
        endcase
    end

endmodule

// File: source/executeSequencer.sv
`timescale 1ns/1ps
`include "controller_params.svh"

module executeSequencer
    import controlPkg::*;
(
    input  logic [`CTRL_STEP_COUNT-1:0]     step,
    input  logic                            running,
    input  logic                            zeroFlag,
    input  opClassT                         opClass,
    input  aluFunT                          aluOp,
    input  logic [`CTRL_REG_CODE_WIDTH-1:0] src1Code,
    input  logic [`CTRL_REG_CODE_WIDTH-1:0] src2Code,
    input  logic                            src1InRf,
    input  logic                            src2InRf,
    input  logic                            isIncrement,
    input  logic [1:0]                      branchKind,
    input  logic [1:0]                      immediateKind,
    output logic                            memEnable,
    output logic                            irWrite,
    output logic                            irHalf,
    output logic [1:0]                      arfOutDSel,
    output logic [1:0]                      arfOutCSel,
    output logic [2:0]                      rfOutASel,
    output logic [2:0]                      rfOutBSel,
    output aluFunT                          aluFunSel,
    output logic                            aluWriteFlags,
    output writeTargetT                     writeTarget,
    output writeSourceT                     writeSource,
    output rfFunT                           writeRfFun,
    output arfFunT                          writeArfFun,
    output logic                            instrDone
);
    localparam logic [2:0] RfOutS1 = 3'b100;
    localparam logic [2:0] RfOutS2 = 3'b101;

    logic       branchTaken;
    logic       src2Staged;
    logic [1:0] arfSources; // operands that need a trip through a scratch register

    function automatic logic [2:0] rfOut(input logic [1:0] idx);
        return {1'b0, idx};
    endfunction

    // source codes PC, PC, SP, AR onto outC order PC, PC, AR, SP
    function automatic logic [1:0] outCSel(input logic [1:0] idx);
        return idx[1] ? {1'b1, ~idx[0]} : idx;
    endfunction

    assign branchTaken = (branchKind == 2'b00)
                         || (branchKind == 2'b01 && !zeroFlag)
                         || (branchKind == 2'b10 && zeroFlag);
    assign src2Staged  = (opClass == classBinary) && !src2InRf;
    assign arfSources  = 2'(!src1InRf) + 2'(src2Staged);

    always_comb begin
        memEnable     = 1'b0;
        irWrite       = 1'b0;
        irHalf        = 1'b0;
        arfOutDSel    = 2'b00; // memory address is always PC
        arfOutCSel    = 2'b00;
        rfOutASel     = 3'b000;
        rfOutBSel     = 3'b000;
        aluFunSel     = aluPassA;
        aluWriteFlags = 1'b0;
        writeTarget   = wtNone;
        writeSource   = wsAlu;
        writeRfFun    = rfHold;
        writeArfFun   = arfHold;
        instrDone     = 1'b0;

        if (running && (step[0] || step[1])) begin
            memEnable   = 1'b1;
            irWrite     = 1'b1;
            irHalf      = step[1];
            writeTarget = wtProgramCounter; // PC++ each byte
            writeArfFun = arfInc;
        end else if (running) begin
            case (opClass)
                classBranch: begin
                    if (step[2]) begin
                        writeTarget = wtScratch1; // offset into S1
                        writeSource = wsIrLow;
                        writeRfFun  = rfLoad;
                    end else if (step[3]) begin
                        writeTarget = wtScratch2; // PC into S2, outC default
                        writeSource = wsArfOut;
                        writeRfFun  = rfLoad;
                    end else if (step[4]) begin
                        rfOutASel   = RfOutS1;
                        rfOutBSel   = RfOutS2;
                        aluFunSel   = aluOp;
                        writeTarget = branchTaken ? wtProgramCounter : wtNone;
                        writeArfFun = arfLoad;
                        instrDone   = 1'b1;
                    end
                end
                classIncDec: begin
                    if (step[2]) begin
                        writeTarget = wtDestination; // copy source first
                        writeRfFun  = rfLoad;
                        writeArfFun = arfLoad;
                        if (src1InRf) begin
                            rfOutASel = rfOut(src1Code[1:0]);
                        end else begin
                            arfOutCSel  = outCSel(src1Code[1:0]);
                            writeSource = wsArfOut;
                        end
                    end else if (step[3]) begin
                        writeTarget   = wtDestination;
                        writeRfFun    = isIncrement ? rfInc : rfDec;
                        writeArfFun   = isIncrement ? arfInc : arfDec;
                        aluWriteFlags = 1'b1;
                        instrDone     = 1'b1;
                    end
                end
                classUnary, classBinary: begin
                    if (step[2 + arfSources]) begin
                        rfOutASel = src1InRf ? rfOut(src1Code[1:0]) : RfOutS1;
                        rfOutBSel = src2InRf ? rfOut(src2Code[1:0])
                                             : (src1InRf ? RfOutS1 : RfOutS2);
                        aluFunSel   = aluOp;
                        writeTarget = wtDestination;
                        writeRfFun  = rfLoad;
                        writeArfFun = arfLoad;
                        instrDone   = 1'b1;
                    end else if (step[2]) begin
                        // first address-file operand into S1
                        writeTarget = wtScratch1;
                        writeSource = wsArfOut;
                        writeRfFun  = rfLoad;
                        arfOutCSel  = outCSel(src1InRf ? src2Code[1:0] : src1Code[1:0]);
                    end else if (step[3]) begin
                        writeTarget = wtScratch2; // both operands were in the address file
                        writeSource = wsArfOut;
                        writeRfFun  = rfLoad;
                        arfOutCSel  = outCSel(src2Code[1:0]);
                    end
                end
                classImmediate: begin
                    if (step[2]) begin
                        writeTarget = wtRselReg;
                        writeSource = wsIrLow;
                        writeRfFun  = immediateKind[1]
                                      ? (immediateKind[0] ? rfLoadHigh : rfLoadLow)
                                      : rfLoad;
                        instrDone   = 1'b1;
                    end
                end
                default: instrDone = step[2]; // no-op
            endcase
        end
    end

endmodule

// File: source/registerWriteSelect.sv
`timescale 1ns/1ps
`include "controller_params.svh"

module registerWriteSelect
    import controlPkg::*;
(
    input  logic                            running,
    input  logic [`CTRL_REG_CODE_WIDTH-1:0] destCode,
    input  logic [1:0]                      rsel,
    input  writeTargetT                     writeTarget,
    input  writeSourceT                     writeSource,
    input  rfFunT                           writeRfFun,
    input  arfFunT                          writeArfFun,
    output logic [3:0]                      rfRegSel,
    output logic [3:0]                      rfScrSel,
    output rfFunT                           rfFunSel,
    output logic [2:0]                      arfRegSel,
    output arfFunT                          arfFunSel,
    output muxASelT                         muxASel,
    output muxBSelT                         muxBSel
);
    logic rfWrite;
    logic arfWrite;

    // active low, R1 is the msb
    function automatic logic [3:0] regMask(input logic [1:0] idx);
        return ~(4'b1000 >> idx);
    endfunction

    function automatic logic [2:0] arfMask(input logic [1:0] idx);
        case (idx)
            2'b10:   return 3'b110; // SP
            2'b11:   return 3'b101; // AR
            default: return 3'b011; // both low codes are PC
        endcase
    endfunction

    always_comb begin
        rfRegSel  = 4'b1111;
        rfScrSel  = 4'b1111;
        arfRegSel = 3'b111;
        rfWrite   = 1'b0;
        arfWrite  = 1'b0;
        if (running) begin
            case (writeTarget)
                wtDestination: begin
                    if (destCode[`CTRL_REG_CODE_WIDTH-1]) begin
                        rfRegSel = regMask(destCode[1:0]);
                        rfWrite  = 1'b1;
                    end else begin
                        arfRegSel = arfMask(destCode[1:0]);
                        arfWrite  = 1'b1;
                    end
                end
                wtRselReg: begin
                    rfRegSel = regMask(rsel);
                    rfWrite  = 1'b1;
                end
                wtScratch1: begin
                    rfScrSel = 4'b0111;
                    rfWrite  = 1'b1;
                end
                wtScratch2: begin
                    rfScrSel = 4'b1011;
                    rfWrite  = 1'b1;
                end
                wtProgramCounter: begin
                    arfRegSel = 3'b011;
                    arfWrite  = 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign rfFunSel  = rfWrite ? writeRfFun : rfHold;
    assign arfFunSel = arfWrite ? writeArfFun : arfHold;

    always_comb begin
        muxASel = muxAAlu;
        muxBSel = muxBAlu;
        if (rfWrite) begin
            case (writeSource)
                wsIrLow:  muxASel = muxAIrLow;
                wsArfOut: muxASel = muxAArfOutC;
                default:  muxASel = muxAAlu;
            endcase
        end
        if (arfWrite && writeSource == wsArfOut) begin
            muxBSel = muxBArfOutC; // address-file copy
        end
    end

endmodule

// File: source/cpuController.sv
`timescale 1ns/1ps
`include "controller_params.svh"

module cpuController
    import controlPkg::*;
(
    input  logic                        Clock,
    input  logic                        rst,
    input  logic [`CTRL_BYTE_WIDTH-1:0] memData,
    input  logic                        zeroFlag,
    output logic [`CTRL_STEP_COUNT-1:0] step,
    output logic [`CTRL_BYTE_WIDTH-1:0] irLow,
    output logic                        memEnable,
    output logic                        irWrite,
    output logic                        irHalf,
    output logic [1:0]                  arfOutDSel,
    output logic [1:0]                  arfOutCSel,
    output logic [2:0]                  rfOutASel,
    output logic [2:0]                  rfOutBSel,
    output aluFunT                      aluFunSel,
    output logic                        aluWriteFlags,
    output logic [3:0]                  rfRegSel,
    output logic [3:0]                  rfScrSel,
    output rfFunT                       rfFunSel,
    output logic [2:0]                  arfRegSel,
    output arfFunT                      arfFunSel,
    output muxASelT                     muxASel,
    output muxBSelT                     muxBSel
);
    logic                            running;
    logic                            instrDone;
    opClassT                         opClass;
    aluFunT                          aluOp;
    logic [1:0]                      rsel;
    logic [`CTRL_REG_CODE_WIDTH-1:0] destCode;
    logic [`CTRL_REG_CODE_WIDTH-1:0] src1Code;
    logic [`CTRL_REG_CODE_WIDTH-1:0] src2Code;
    logic                            src1InRf;
    logic                            src2InRf;
    logic                            isIncrement;
    logic [1:0]                      branchKind;
    logic [1:0]                      immediateKind;
    writeTargetT                     writeTarget;
    writeSourceT                     writeSource;
    rfFunT                           writeRfFun;
    arfFunT                          writeArfFun;

    sequenceCounter counterI (.*);

    instructionDecoder decoderI (.*);

    executeSequencer sequencerI (.*);

    registerWriteSelect writeSelectI (.*);

endmodule

// File: bench/controllerChecks.svh
`ifndef CONTROLLER_CHECKS_SVH
`define CONTROLLER_CHECKS_SVH

task automatic failRun(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "controller test stopped");
endtask

task automatic checkBits(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        failRun($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
    end
endtask

task automatic checkStep(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
        failRun($sformatf("[FAIL] %0t step got %b expected %b", $time, got, exp));
    end
endtask

task automatic checkRf(input string name, input rfFunT gotFun, input logic [3:0] gotMask,
                       input rfFunT expFun, input logic [3:0] expMask);
    if (gotFun !== expFun) begin
        failRun($sformatf("[FAIL] %0t rfFunSel got %b expected %b", $time, gotFun, expFun));
    end
    checkBits(name, {4'b0, gotMask}, {4'b0, expMask});
endtask

task automatic checkArf(input arfFunT gotFun, input logic [2:0] gotMask,
                        input arfFunT expFun, input logic [2:0] expMask);
    if (gotFun !== expFun) begin
        failRun($sformatf("[FAIL] %0t arfFunSel got %b expected %b", $time, gotFun, expFun));
    end
    checkBits("arfRegSel", {5'b0, gotMask}, {5'b0, expMask});
endtask

task automatic checkAlu(input aluFunT got, input aluFunT exp);
    if (got !== exp) begin
        failRun($sformatf("[FAIL] %0t aluFunSel got %b expected %b", $time, got, exp));
    end
endtask

// active low, R1 first
function automatic logic [3:0] regMaskOf(input logic [1:0] idx);
    case (idx)
        2'd0:    return 4'b0111;
        2'd1:    return 4'b1011;
        2'd2:    return 4'b1101;
        default: return 4'b1110;
    endcase
endfunction

function automatic logic [2:0] arfMaskOf(input logic [1:0] idx);
    case (idx)
        2'd2:    return 3'b110; // SP
        2'd3:    return 3'b101; // AR
        default: return 3'b011; // PC
    endcase
endfunction

// outC order is PC, PC, AR, SP
function automatic logic [1:0] outCFor(input logic [1:0] code);
    case (code)
        2'd2:    return 2'b11; // SP
        2'd3:    return 2'b10; // AR
        default: return code; // both PC codes
    endcase
endfunction

function automatic aluFunT expectedAlu(input logic [5:0] op);
    case (op)
        6'h07: return aluLsl;
        6'h08: return aluLsr;
        6'h09: return aluAsr;
        6'h0A: return aluCsl;
        6'h0B: return aluCsr;
        6'h0C: return aluAnd;
        6'h0D: return aluOr;
        6'h0E: return aluNotA;
        6'h0F: return aluXor;
        6'h10: return aluNand;
        6'h15: return aluAdd;
        6'h16: return aluAddCarry;
        6'h17: return aluSub;
        default: return aluPassA;
    endcase
endfunction

`endif

// File: bench/controllerTb.sv
`timescale 1ns/1ps
`include "controller_params.svh"

module controllerTb
    import controlPkg::*;
;
    localparam int MaxCycles = 400; // about 60 instructions of up to 5 cycles, plus margin

    logic Clock, rst, zeroFlag, memEnable, irWrite, irHalf, aluWriteFlags;
    logic [7:0] memData, step, irLow, modelPc;
    logic [1:0] arfOutDSel, arfOutCSel;
    logic [2:0] rfOutASel, rfOutBSel, arfRegSel;
    logic [3:0] rfRegSel, rfScrSel;
    aluFunT aluFunSel;
    rfFunT rfFunSel;
    arfFunT arfFunSel;
    muxASelT muxASel;
    muxBSelT muxBSel;
    logic [7:0] mem [0:255];
    int cycles = 0;

    cpuController dut_i (.*);

    `include "controllerChecks.svh"

    initial begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    always @(posedge Clock) begin
        cycles <= cycles + 1;
        if (cycles >= MaxCycles) failRun("timeout: the DUT never finished the directed tests");
    end

    // byte memory, advances on each fetch
    always @(posedge Clock) begin
        if (rst) begin
            modelPc <= 8'd0;
            memData <= mem[0];
        end else if (memEnable) begin
            modelPc <= modelPc + 8'd1;
            memData <= mem[modelPc + 8'd1];
        end
    end

    task automatic advance(input int n);
        @(negedge Clock);
        checkStep(step, 8'b1 << n);
    endtask

    task automatic checkFetch(input logic half);
        checkBits("memEnable", {7'b0, memEnable}, 8'd1);
        checkBits("irWrite", {7'b0, irWrite}, 8'd1);
        checkBits("irHalf", {7'b0, irHalf}, {7'b0, half});
        checkBits("arfOutDSel", {6'b0, arfOutDSel}, 8'd0); // address from PC
        checkArf(arfFunSel, arfRegSel, arfInc, 3'b011);
    endtask

    task automatic checkIdle();
        checkBits("memEnable", {7'b0, memEnable}, 8'd0);
        checkBits("irWrite", {7'b0, irWrite}, 8'd0);
        checkBits("aluWriteFlags", {7'b0, aluWriteFlags}, 8'd0);
        checkBits("rfRegSel", {4'b0, rfRegSel}, 8'h0F);
        checkBits("rfScrSel", {4'b0, rfScrSel}, 8'h0F);
        checkBits("arfRegSel", {5'b0, arfRegSel}, 8'h07);
    endtask

    task automatic checkDest(input logic [2:0] dest, input rfFunT rfExp, input arfFunT arfExp);
        if (dest[2]) checkRf("rfRegSel", rfFunSel, rfRegSel, rfExp, regMaskOf(dest[1:0]));
        else checkArf(arfFunSel, arfRegSel, arfExp, arfMaskOf(dest[1:0]));
    endtask

    // an address-file register copied into a scratch register through outC
    task automatic checkScratch(input logic [3:0] mask, input logic [1:0] code);
        checkRf("rfScrSel", rfFunSel, rfScrSel, rfLoad, mask);
        checkBits("muxASel", {6'b0, muxASel}, {6'b0, muxAArfOutC});
        checkBits("arfOutCSel", {6'b0, arfOutCSel}, {6'b0, outCFor(code)});
    endtask

    // places the word behind the filler no-op now fetching and runs up to its T2
    task automatic startInstr(input logic [15:0] word, input logic zf);
        while (!(step[0] && memEnable)) @(negedge Clock);
        mem[modelPc + 8'd2] = word[7:0];
        mem[modelPc + 8'd3] = word[15:8];
        @(posedge Clock);
        zeroFlag <= zf;
        advance(1);
        advance(2);
        advance(0);
        checkFetch(1'b0);
        advance(1);
        checkFetch(1'b1);
        advance(2);
    endtask

    task automatic runAlu(input logic [5:0] op, input logic binary);
        logic [15:0] word;
        logic [1:0] staged [$]; // address-file sources in staging order
        logic [2:0] expA;
        logic [2:0] expB;
        word = 16'($urandom);
        word[15:10] = op;
        if (!word[5]) staged.push_back(word[4:3]);
        if (binary && !word[2]) staged.push_back(word[1:0]);
        expA = word[5] ? {1'b0, word[4:3]} : 3'b100;
        expB = word[2] ? {1'b0, word[1:0]} : ((staged.size() == 2) ? 3'b101 : 3'b100);
        startInstr(word, 1'($urandom));
        foreach (staged[i]) begin
            checkScratch((i == 0) ? 4'b0111 : 4'b1011, staged[i]);
            advance(3 + i);
        end
        checkAlu(aluFunSel, expectedAlu(op));
        checkDest({word[8], word[7:6]}, rfLoad, arfLoad);
        checkBits("rfOutASel", {5'b0, rfOutASel}, {5'b0, expA});
        if (binary) checkBits("rfOutBSel", {5'b0, rfOutBSel}, {5'b0, expB});
        checkBits("muxBSel", {6'b0, muxBSel}, {6'b0, muxBAlu});
        advance(0);
    endtask

    task automatic testBranches();
        logic [15:0] word;
        logic taken;
        for (int kind = 0; kind < 3; kind++) begin
            for (int zf = 0; zf < 2; zf++) begin
                word = {6'(kind), 10'($urandom)};
                taken = (kind == 0) || (kind == 1 && zf == 0) || (kind == 2 && zf == 1);
                startInstr(word, 1'(zf));
                checkRf("rfScrSel", rfFunSel, rfScrSel, rfLoad, 4'b0111); // offset into S1
                checkBits("muxASel", {6'b0, muxASel}, {6'b0, muxAIrLow});
                advance(3);
                checkScratch(4'b1011, 2'b00); // PC into S2
                advance(4);
                checkAlu(aluFunSel, aluAdd);
                checkBits("rfOutASel", {5'b0, rfOutASel}, 8'd4); // S1
                checkBits("rfOutBSel", {5'b0, rfOutBSel}, 8'd5); // S2
                if (taken) checkArf(arfFunSel, arfRegSel, arfLoad, 3'b011);
                else checkArf(arfFunSel, arfRegSel, arfHold, 3'b111);
                advance(0);
            end
        end
    endtask

    task automatic testIncDec();
        logic [15:0] word;
        for (int inc = 0; inc < 2; inc++) begin
            word = {(inc == 1) ? 6'h05 : 6'h06, 10'($urandom)};
            startInstr(word, 1'b0);
            checkDest({word[8], word[7:6]}, rfLoad, arfLoad);
            if (word[5]) begin
                checkBits("rfOutASel", {5'b0, rfOutASel}, {6'b0, word[4:3]});
            end else begin
                checkBits("arfOutCSel", {6'b0, arfOutCSel}, {6'b0, outCFor(word[4:3])});
            end
            checkBits("muxASel", {6'b0, muxASel},
                      {6'b0, (word[8] && !word[5]) ? muxAArfOutC : muxAAlu});
            checkBits("muxBSel", {6'b0, muxBSel},
                      {6'b0, (!word[8] && !word[5]) ? muxBArfOutC : muxBAlu});
            advance(3);
            checkDest({word[8], word[7:6]}, (inc == 1) ? rfInc : rfDec,
                      (inc == 1) ? arfInc : arfDec);
            checkBits("aluWriteFlags", {7'b0, aluWriteFlags}, 8'd1);
            advance(0);
        end
    endtask

    task automatic runImmediate(input logic [5:0] op, input rfFunT expFun);
        logic [15:0] word;
        word = {op, 10'($urandom)};
        startInstr(word, 1'b0);
        checkRf("rfRegSel", rfFunSel, rfRegSel, expFun, regMaskOf(word[9:8]));
        checkBits("muxASel", {6'b0, muxASel}, {6'b0, muxAIrLow});
        checkBits("irLow", irLow, word[7:0]);
        advance(0);
    endtask

    initial begin
        logic [5:0] binOps [7] = '{6'h0C, 6'h0D, 6'h0F, 6'h10, 6'h15, 6'h16, 6'h17};
        logic [5:0] unOps [6] = '{6'h07, 6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0E};
        void'($urandom(25236));
        rst = 1'b1;
        zeroFlag = 1'b0;
        memData = 8'h00;
        // filler no-ops with opcode 0x3F and the address folded into the other bits
        for (int a = 0; a < 256; a++) begin
            mem[a] = a[0] ? {6'h3F, a[1:0] ^ a[3:2] ^ a[5:4] ^ a[7:6]} : 8'(a);
        end
        repeat (4) @(posedge Clock);
        @(negedge Clock);
        checkIdle();
        @(posedge Clock);
        rst <= 1'b0;
        @(negedge Clock);
        checkIdle(); // reset was still sampled at this edge
        advance(0);
        checkFetch(1'b0);
        advance(1);
        checkFetch(1'b1);
        foreach (binOps[i]) runAlu(binOps[i], 1'b1);
        testBranches();
        testIncDec();
        runImmediate(6'h11, rfLoadHigh);
        runImmediate(6'h14, rfLoadLow);
        runImmediate(6'h20, rfLoad);
        foreach (unOps[i]) runAlu(unOps[i], 1'b0);
        startInstr({6'h03, 10'($urandom)}, 1'b0); // undefined opcode
        checkIdle();
        advance(0);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: project.f
+incdir+source
+incdir+bench
source/controlPkg.sv
source/sequenceCounter.sv
source/instructionDecoder.sv
source/executeSequencer.sv
source/registerWriteSelect.sv
source/cpuController.sv
bench/controllerTb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module controllerTb -o controllerSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/controllerSim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "RESULT: PASS" <<< "$output"; then
    exit 0
fi
exit 1
